//--- build.f
common/isa_pkg.sv
common/pipe_pkg.sv
rtl/reg_file.sv
rtl/decoder.sv
rtl/id_ex.sv
rtl/execute.sv
rtl/stall_ctrl.sv
rtl/id_ex_core.sv
sim/tb_id_ex_core.sv

//--- common/isa_pkg.sv
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  func3_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL,
        ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_BRANCH, ALU_JUMP
    } alu_op_t;

    // Major opcodes, inst[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // Arithmetic funct3
    localparam func3_t F3_ADD  = 3'b000;
    localparam func3_t F3_SLL  = 3'b001;
    localparam func3_t F3_SLT  = 3'b010;
    localparam func3_t F3_SLTU = 3'b011;
    localparam func3_t F3_XOR  = 3'b100;
    localparam func3_t F3_SR   = 3'b101;
    localparam func3_t F3_OR   = 3'b110;
    localparam func3_t F3_AND  = 3'b111;

    // Branch funct3
    localparam func3_t F3_BEQ  = 3'b000;
    localparam func3_t F3_BNE  = 3'b001;
    localparam func3_t F3_BLT  = 3'b100;
    localparam func3_t F3_BGE  = 3'b101;
    localparam func3_t F3_BLTU = 3'b110;
    localparam func3_t F3_BGEU = 3'b111;

    localparam logic SRC1_REG = 1'b0;
    localparam logic SRC1_PC  = 1'b1;
    localparam logic SRC2_REG = 1'b0;
    localparam logic SRC2_IMM = 1'b1;

    localparam reg_addr_t NOP_REG = 5'd0;

endpackage

//--- common/pipe_pkg.sv
package pipe_pkg;

    localparam int STAGE_NUM = 5;

    // Positions in the stall vector
    localparam int IF_STAGE = 0;
    localparam int ID_STAGE = 1;
    localparam int EX_STAGE = 2;

    typedef logic [STAGE_NUM-1:0] stall_t;

    // Decoded instruction on its way into execute
    typedef struct packed {
        isa_pkg::word_t     pc;
        isa_pkg::func3_t    func3;
        isa_pkg::alu_op_t   aluop;
        logic               alusrc1;
        logic               alusrc2;
        isa_pkg::word_t     imm;
        isa_pkg::word_t     rs1;
        isa_pkg::word_t     rs2;
        isa_pkg::reg_addr_t rd;
        logic               wreg;
        logic               memrd;
        logic               memwr;
        logic               mem2reg;
        isa_pkg::word_t     link_addr;
        logic               is_in_delayslot;
    } id_ex_t;

    // Execute result toward the memory stage
    typedef struct packed {
        isa_pkg::word_t     result;
        isa_pkg::word_t     store_data;
        isa_pkg::reg_addr_t rd;
        logic               wreg;
        logic               memrd;
        logic               memwr;
        logic               mem2reg;
        isa_pkg::func3_t    func3;
        logic               in_delayslot;
    } ex_out_t;

endpackage

//--- rtl/decoder.sv
`timescale 1ns/1ns

module decoder (
    input  isa_pkg::word_t     pc,
    input  isa_pkg::word_t     inst,
    input  logic               is_in_delayslot,
    input  isa_pkg::word_t     rs1_data,
    input  isa_pkg::word_t     rs2_data,
    output isa_pkg::reg_addr_t rs1_addr,
    output isa_pkg::reg_addr_t rs2_addr,
    output pipe_pkg::id_ex_t   id_bus,
    output logic               next_in_delayslot
);

    logic [6:0]      opcode;
    isa_pkg::func3_t f3;
    isa_pkg::word_t  imm_i;
    isa_pkg::word_t  imm_s;
    isa_pkg::word_t  imm_b;
    isa_pkg::word_t  imm_u;
    isa_pkg::word_t  imm_j;

    function automatic isa_pkg::alu_op_t arith_op(input isa_pkg::func3_t fn, input logic alt);
        case (fn)
            isa_pkg::F3_ADD:  return alt ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
            isa_pkg::F3_SLL:  return isa_pkg::ALU_SLL;
            isa_pkg::F3_SLT:  return isa_pkg::ALU_SLT;
            isa_pkg::F3_SLTU: return isa_pkg::ALU_SLTU;
            isa_pkg::F3_XOR:  return isa_pkg::ALU_XOR;
            isa_pkg::F3_SR:   return alt ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
            isa_pkg::F3_OR:   return isa_pkg::ALU_OR;
            default:          return isa_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode = inst[6:0];
    assign f3     = inst[14:12];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // Only real source registers are read, so the hazard check sees no false matches
    always_comb begin
        rs1_addr = isa_pkg::NOP_REG;
        rs2_addr = isa_pkg::NOP_REG;
        case (opcode)
            isa_pkg::OPC_OP, isa_pkg::OPC_STORE, isa_pkg::OPC_BRANCH: begin
                rs1_addr = inst[19:15];
                rs2_addr = inst[24:20];
            end
            isa_pkg::OPC_OP_IMM, isa_pkg::OPC_LOAD, isa_pkg::OPC_JALR: begin
                rs1_addr = inst[19:15];
            end
            default: ;
        endcase
    end

    always_comb begin
        id_bus                 = '0;
        id_bus.pc              = pc;
        id_bus.func3           = f3;
        id_bus.aluop           = isa_pkg::ALU_ADD;
        id_bus.alusrc1         = isa_pkg::SRC1_REG;
        id_bus.alusrc2         = isa_pkg::SRC2_REG;
        id_bus.rs1             = rs1_data;
        id_bus.rs2             = rs2_data;
        id_bus.rd              = isa_pkg::NOP_REG;
        id_bus.link_addr       = pc + 32'd8;
        id_bus.is_in_delayslot = is_in_delayslot;
        next_in_delayslot      = 1'b0;

        case (opcode)
            isa_pkg::OPC_OP: begin
                id_bus.aluop = arith_op(f3, inst[30]);
                id_bus.rd    = inst[11:7];
                id_bus.wreg  = 1'b1;
            end
            isa_pkg::OPC_OP_IMM: begin
                // Bit 30 only selects SRAI, never a subtract
                id_bus.aluop   = arith_op(f3, f3 == isa_pkg::F3_SR && inst[30]);
                id_bus.alusrc2 = isa_pkg::SRC2_IMM;
                id_bus.imm     = imm_i;
                id_bus.rd      = inst[11:7];
                id_bus.wreg    = 1'b1;
            end
            isa_pkg::OPC_LUI: begin
                id_bus.aluop   = isa_pkg::ALU_LUI;
                id_bus.alusrc2 = isa_pkg::SRC2_IMM;
                id_bus.imm     = imm_u;
                id_bus.rd      = inst[11:7];
                id_bus.wreg    = 1'b1;
            end
            isa_pkg::OPC_AUIPC: begin
                id_bus.alusrc1 = isa_pkg::SRC1_PC;
                id_bus.alusrc2 = isa_pkg::SRC2_IMM;
                id_bus.imm     = imm_u;
                id_bus.rd      = inst[11:7];
                id_bus.wreg    = 1'b1;
            end
            isa_pkg::OPC_LOAD: begin
                id_bus.alusrc2 = isa_pkg::SRC2_IMM;
                id_bus.imm     = imm_i;
                id_bus.rd      = inst[11:7];
                id_bus.wreg    = 1'b1;
                id_bus.memrd   = 1'b1;
                id_bus.mem2reg = 1'b1;
            end
            isa_pkg::OPC_STORE: begin
                id_bus.alusrc2 = isa_pkg::SRC2_IMM;
                id_bus.imm     = imm_s;
                id_bus.memwr   = 1'b1;
            end
            isa_pkg::OPC_BRANCH: begin
                id_bus.aluop      = isa_pkg::ALU_BRANCH;
                id_bus.imm        = imm_b;
                next_in_delayslot = 1'b1;
            end
            isa_pkg::OPC_JAL: begin
                id_bus.aluop      = isa_pkg::ALU_JUMP;
                id_bus.alusrc1    = isa_pkg::SRC1_PC;
                id_bus.imm        = imm_j;
                id_bus.rd         = inst[11:7];
                id_bus.wreg       = 1'b1;
                next_in_delayslot = 1'b1;
            end
            isa_pkg::OPC_JALR: begin
                id_bus.aluop      = isa_pkg::ALU_JUMP;
                id_bus.imm        = imm_i;
                id_bus.rd         = inst[11:7];
                id_bus.wreg       = 1'b1;
                next_in_delayslot = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- rtl/execute.sv
`timescale 1ns/1ns

module execute (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  pipe_pkg::id_ex_t  ex_bus,
    output pipe_pkg::ex_out_t ex_out,
    output logic              branch_taken,
    output isa_pkg::word_t    branch_target
);

    isa_pkg::word_t op1;
    isa_pkg::word_t op2;
    isa_pkg::word_t alu_res;
    isa_pkg::word_t target;
    logic           cond;

    assign op1 = (ex_bus.alusrc1 == isa_pkg::SRC1_PC) ? ex_bus.pc : ex_bus.rs1;
    assign op2 = (ex_bus.alusrc2 == isa_pkg::SRC2_IMM) ? ex_bus.imm : ex_bus.rs2;

    always_comb begin
        case (ex_bus.aluop)
            isa_pkg::ALU_ADD:  alu_res = op1 + op2;
            isa_pkg::ALU_SUB:  alu_res = op1 - op2;
            isa_pkg::ALU_SLL:  alu_res = op1 << op2[4:0];
            isa_pkg::ALU_SLT:  alu_res = {31'b0, $signed(op1) < $signed(op2)};
            isa_pkg::ALU_SLTU: alu_res = {31'b0, op1 < op2};
            isa_pkg::ALU_XOR:  alu_res = op1 ^ op2;
            isa_pkg::ALU_SRL:  alu_res = op1 >> op2[4:0];
            isa_pkg::ALU_SRA:  alu_res = isa_pkg::word_t'($signed(op1) >>> op2[4:0]);
            isa_pkg::ALU_OR:   alu_res = op1 | op2;
            isa_pkg::ALU_AND:  alu_res = op1 & op2;
            isa_pkg::ALU_LUI:  alu_res = op2;
            isa_pkg::ALU_JUMP: alu_res = ex_bus.link_addr;
            default:           alu_res = '0;
        endcase
    end

    always_comb begin
        case (ex_bus.func3)
            isa_pkg::F3_BEQ:  cond = ex_bus.rs1 == ex_bus.rs2;
            isa_pkg::F3_BNE:  cond = ex_bus.rs1 != ex_bus.rs2;
            isa_pkg::F3_BLT:  cond = $signed(ex_bus.rs1) < $signed(ex_bus.rs2);
            isa_pkg::F3_BGE:  cond = $signed(ex_bus.rs1) >= $signed(ex_bus.rs2);
            isa_pkg::F3_BLTU: cond = ex_bus.rs1 < ex_bus.rs2;
            isa_pkg::F3_BGEU: cond = ex_bus.rs1 >= ex_bus.rs2;
            default:          cond = 1'b0;
        endcase
    end

    // JALR is the only jump that takes its base from rs1
    assign target = (ex_bus.aluop == isa_pkg::ALU_JUMP && ex_bus.alusrc1 == isa_pkg::SRC1_REG) ?
                    ((ex_bus.rs1 + ex_bus.imm) & ~32'd1) : (ex_bus.pc + ex_bus.imm);

    assign branch_taken  = (ex_bus.aluop == isa_pkg::ALU_JUMP) ||
                           (ex_bus.aluop == isa_pkg::ALU_BRANCH && cond);
    assign branch_target = branch_taken ? target : '0;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ex_out <= '0;
        end else if (flush) begin
            ex_out <= '0;
        end else begin
            ex_out.result       <= alu_res;
            ex_out.store_data   <= ex_bus.rs2;
            ex_out.rd           <= ex_bus.rd;
            ex_out.wreg         <= ex_bus.wreg;
            ex_out.memrd        <= ex_bus.memrd;
            ex_out.memwr        <= ex_bus.memwr;
            ex_out.mem2reg      <= ex_bus.mem2reg;
            ex_out.func3        <= ex_bus.func3;
            ex_out.in_delayslot <= ex_bus.is_in_delayslot;
        end
    end

endmodule

//--- rtl/id_ex.sv
`timescale 1ns/1ns

module id_ex (
    input  logic             clk,
    input  logic             rst,
    input  pipe_pkg::id_ex_t id_bus,
    input  logic             next_in_delayslot,
    input  pipe_pkg::stall_t stall,
    input  logic             flush,
    output pipe_pkg::id_ex_t ex_bus,
    output logic             is_id_in_delayslot
);

    logic id_hold;
    logic bubble;
    logic next_d;

    assign id_hold = stall[pipe_pkg::ID_STAGE];

    // Decode held while execute moves on means an empty slot
    assign bubble = flush || (id_hold && !stall[pipe_pkg::EX_STAGE]);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ex_bus <= '0;
        end else if (bubble) begin
            ex_bus <= '0;
        end else if (!id_hold) begin
            ex_bus <= id_bus;
        end
    end

    // Flag follows the branch only once it has really left decode
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            next_d <= 1'b0;
        end else if (flush) begin
            next_d <= 1'b0;
        end else if (!id_hold) begin
            next_d <= next_in_delayslot;
        end
    end

    assign is_id_in_delayslot = next_d;

endmodule

//--- rtl/id_ex_core.sv
`timescale 1ns/1ns

module id_ex_core (
    input  logic               clk,
    input  logic               rst,
    input  isa_pkg::word_t     if_pc,
    input  isa_pkg::word_t     if_inst,
    input  logic               flush,
    input  logic               wb_we,
    input  isa_pkg::reg_addr_t wb_rd,
    input  isa_pkg::word_t     wb_data,
    output pipe_pkg::ex_out_t  ex_out,
    output logic               branch_taken,
    output isa_pkg::word_t     branch_target,
    output logic               id_stall
);

    isa_pkg::reg_addr_t rs1_addr;
    isa_pkg::reg_addr_t rs2_addr;
    isa_pkg::word_t     rs1_data;
    isa_pkg::word_t     rs2_data;
    pipe_pkg::id_ex_t   id_bus;
    pipe_pkg::id_ex_t   ex_bus;
    pipe_pkg::stall_t   stall;
    logic               next_in_delayslot;
    logic               is_id_in_delayslot;

    reg_file u_reg_file (
        .clk    (clk),
        .rst    (rst),
        .we     (wb_we),
        .waddr  (wb_rd),
        .wdata  (wb_data),
        .raddr1 (rs1_addr),
        .raddr2 (rs2_addr),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    decoder u_decoder (
        .pc                (if_pc),
        .inst              (if_inst),
        .is_in_delayslot   (is_id_in_delayslot),
        .rs1_data          (rs1_data),
        .rs2_data          (rs2_data),
        .rs1_addr          (rs1_addr),
        .rs2_addr          (rs2_addr),
        .id_bus            (id_bus),
        .next_in_delayslot (next_in_delayslot)
    );

    id_ex u_id_ex (
        .clk                (clk),
        .rst                (rst),
        .id_bus             (id_bus),
        .next_in_delayslot  (next_in_delayslot),
        .stall              (stall),
        .flush              (flush),
        .ex_bus             (ex_bus),
        .is_id_in_delayslot (is_id_in_delayslot)
    );

    stall_ctrl u_stall_ctrl (
        .ex_memrd (ex_bus.memrd),
        .ex_rd    (ex_bus.rd),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .stall    (stall),
        .id_stall (id_stall)
    );

    execute u_execute (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .ex_bus        (ex_bus),
        .ex_out        (ex_out),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  logic               we,
    input  isa_pkg::reg_addr_t waddr,
    input  isa_pkg::word_t     wdata,
    input  isa_pkg::reg_addr_t raddr1,
    input  isa_pkg::reg_addr_t raddr2,
    output isa_pkg::word_t     rdata1,
    output isa_pkg::word_t     rdata2
);

    isa_pkg::word_t regs [32];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != isa_pkg::NOP_REG) begin
            regs[waddr] <= wdata;
        end
    end

    // Same-cycle write is visible on the read ports
    always_comb begin
        if (raddr1 == isa_pkg::NOP_REG) begin
            rdata1 = '0;
        end else if (we && waddr == raddr1) begin
            rdata1 = wdata;
        end else begin
            rdata1 = regs[raddr1];
        end

        if (raddr2 == isa_pkg::NOP_REG) begin
            rdata2 = '0;
        end else if (we && waddr == raddr2) begin
            rdata2 = wdata;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

//--- rtl/stall_ctrl.sv
`timescale 1ns/1ns

module stall_ctrl (
    input  logic               ex_memrd,
    input  isa_pkg::reg_addr_t ex_rd,
    input  isa_pkg::reg_addr_t rs1_addr,
    input  isa_pkg::reg_addr_t rs2_addr,
    output pipe_pkg::stall_t   stall,
    output logic               id_stall
);

    logic load_use;

    // Load result not ready yet for a reader right behind it
    assign load_use = ex_memrd && ex_rd != isa_pkg::NOP_REG &&
                      (ex_rd == rs1_addr || ex_rd == rs2_addr);

    always_comb begin
        stall                     = '0;
        stall[pipe_pkg::IF_STAGE] = load_use;
        stall[pipe_pkg::ID_STAGE] = load_use;
    end

    assign id_stall = load_use;

endmodule

//--- sim/tb_id_ex_core.sv
`timescale 1ns/1ns

module tb_id_ex_core;

    typedef struct packed {
        isa_pkg::word_t     pc;
        isa_pkg::word_t     inst;
        logic               flush;
        logic               wb_we;
        isa_pkg::reg_addr_t wb_rd;
        isa_pkg::word_t     wb_data;
        logic               bubble;
    } row_t;

    logic               clk;
    logic               rst;
    isa_pkg::word_t     if_pc;
    isa_pkg::word_t     if_inst;
    logic               flush;
    logic               wb_we;
    isa_pkg::reg_addr_t wb_rd;
    isa_pkg::word_t     wb_data;
    pipe_pkg::ex_out_t  ex_out;
    logic               branch_taken;
    isa_pkg::word_t     branch_target;
    logic               id_stall;

    // Reference model state, one entry per pipeline stage
    isa_pkg::word_t     rf [32];
    pipe_pkg::ex_out_t  exp_ex;
    logic               exp_taken;
    isa_pkg::word_t     exp_target;
    pipe_pkg::ex_out_t  exp_mem;
    logic               ds_flag;

    row_t               rows [$];
    isa_pkg::word_t     next_pc;
    logic [31:0]        rng;
    int                 errors;
    int                 checks;
    int                 waited;

    id_ex_core UUT (
        .clk           (clk),
        .rst           (rst),
        .if_pc         (if_pc),
        .if_inst       (if_inst),
        .flush         (flush),
        .wb_we         (wb_we),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .ex_out        (ex_out),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .id_stall      (id_stall)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic isa_pkg::word_t enc_r(input logic [6:0] f7, input isa_pkg::reg_addr_t rs2,
                                             input isa_pkg::reg_addr_t rs1,
                                             input isa_pkg::func3_t f3,
                                             input isa_pkg::reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, isa_pkg::OPC_OP};
    endfunction

    function automatic isa_pkg::word_t enc_i(input int imm, input isa_pkg::reg_addr_t rs1,
                                             input isa_pkg::func3_t f3,
                                             input isa_pkg::reg_addr_t rd, input logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic isa_pkg::word_t enc_s(input int imm, input isa_pkg::reg_addr_t rs2,
                                             input isa_pkg::reg_addr_t rs1,
                                             input isa_pkg::func3_t f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], isa_pkg::OPC_STORE};
    endfunction

    function automatic isa_pkg::word_t enc_b(input int imm, input isa_pkg::reg_addr_t rs2,
                                             input isa_pkg::reg_addr_t rs1,
                                             input isa_pkg::func3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], isa_pkg::OPC_BRANCH};
    endfunction

    function automatic isa_pkg::word_t enc_u(input logic [19:0] imm, input isa_pkg::reg_addr_t rd,
                                             input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic isa_pkg::word_t enc_j(input int imm, input isa_pkg::reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, isa_pkg::OPC_JAL};
    endfunction

    // Register read as decode sees it, including a write in the same cycle
    function automatic isa_pkg::word_t read_reg(input isa_pkg::reg_addr_t a);
        if (a == 5'd0) begin
            return '0;
        end
        if (wb_we && wb_rd == a) begin
            return wb_data;
        end
        return rf[a];
    endfunction

    function automatic isa_pkg::word_t alu(input isa_pkg::func3_t f3, input logic alt,
                                           input isa_pkg::word_t a, input isa_pkg::word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_cond(input isa_pkg::func3_t f3, input isa_pkg::word_t a,
                                         input isa_pkg::word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Expected execute outcome of one instruction, straight from the RV32I rules
    function automatic pipe_pkg::ex_out_t predict(input isa_pkg::word_t pc,
                                                  input isa_pkg::word_t inst, input logic ds,
                                                  output logic taken,
                                                  output isa_pkg::word_t target);
        pipe_pkg::ex_out_t e;
        isa_pkg::func3_t   f3;
        isa_pkg::word_t    a;
        isa_pkg::word_t    b;
        isa_pkg::word_t    imm_i;
        isa_pkg::word_t    imm_s;
        isa_pkg::word_t    imm_b;
        isa_pkg::word_t    imm_u;
        isa_pkg::word_t    imm_j;
        f3 = inst[14:12];
        a = read_reg(inst[19:15]);
        b = read_reg(inst[24:20]);
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_u = {inst[31:12], 12'h000};
        imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        e = '0;
        e.func3 = f3;
        e.in_delayslot = ds;
        taken = 1'b0;
        target = '0;
        case (inst[6:0])
            isa_pkg::OPC_OP: begin
                e.result = alu(f3, inst[30], a, b);
                e.store_data = b;
                e.rd = inst[11:7];
                e.wreg = 1'b1;
            end
            isa_pkg::OPC_OP_IMM: begin
                e.result = alu(f3, f3 == 3'b101 && inst[30], a, imm_i);
                e.rd = inst[11:7];
                e.wreg = 1'b1;
            end
            isa_pkg::OPC_LUI, isa_pkg::OPC_AUIPC: begin
                e.result = (inst[6:0] == isa_pkg::OPC_LUI) ? imm_u : pc + imm_u;
                e.rd = inst[11:7];
                e.wreg = 1'b1;
            end
            isa_pkg::OPC_LOAD: begin
                e.result = a + imm_i;
                e.rd = inst[11:7];
                e.wreg = 1'b1;
                e.memrd = 1'b1;
                e.mem2reg = 1'b1;
            end
            isa_pkg::OPC_STORE: begin
                e.result = a + imm_s;
                e.store_data = b;
                e.memwr = 1'b1;
            end
            isa_pkg::OPC_BRANCH: begin
                e.store_data = b;
                taken = branch_cond(f3, a, b);
                target = pc + imm_b;
            end
            isa_pkg::OPC_JAL, isa_pkg::OPC_JALR: begin
                // Link skips the delay slot
                e.result = pc + 32'd8;
                e.rd = inst[11:7];
                e.wreg = 1'b1;
                taken = 1'b1;
                target = (inst[6:0] == isa_pkg::OPC_JAL) ? pc + imm_j : (a + imm_i) & ~32'd1;
            end
            default: ;
        endcase
        return e;
    endfunction

    task automatic check_word(input string name, input isa_pkg::word_t exp,
                              input isa_pkg::word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s expected %h got %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s expected %h got %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_ex_out(input pipe_pkg::ex_out_t exp, input pipe_pkg::ex_out_t act);
        check_word("ex_out.result", exp.result, act.result);
        check_word("ex_out.store_data", exp.store_data, act.store_data);
        checks++;
        if (act.rd !== exp.rd) begin
            errors++;
            $display("FAIL ex_out.rd expected %h got %h at %0t", exp.rd, act.rd, $time);
        end
        checks++;
        if (act.func3 !== exp.func3) begin
            errors++;
            $display("FAIL ex_out.func3 expected %h got %h at %0t", exp.func3, act.func3, $time);
        end
        check_bit("ex_out.wreg", exp.wreg, act.wreg);
        check_bit("ex_out.memrd", exp.memrd, act.memrd);
        check_bit("ex_out.memwr", exp.memwr, act.memwr);
        check_bit("ex_out.mem2reg", exp.mem2reg, act.mem2reg);
        check_bit("ex_out.in_delayslot", exp.in_delayslot, act.in_delayslot);
    endtask

    task automatic add_row(input isa_pkg::word_t inst, input logic bubble = 1'b0,
                           input logic fl = 1'b0, input logic we = 1'b0,
                           input isa_pkg::reg_addr_t rd = '0, input isa_pkg::word_t data = '0);
        row_t r;
        r.pc = next_pc;
        r.inst = inst;
        r.flush = fl;
        r.wb_we = we;
        r.wb_rd = rd;
        r.wb_data = data;
        r.bubble = bubble;
        rows.push_back(r);
        next_pc = next_pc + 32'd4;
    endtask

    // One clock: drive, check in mid cycle, then advance the model past the edge
    task automatic run_cycle(input row_t r, input logic exp_stall);
        pipe_pkg::ex_out_t nxt;
        logic              nt;
        isa_pkg::word_t    ntg;
        logic              cti;
        @(posedge clk);
        #2;
        if_pc = r.pc;
        if_inst = r.inst;
        flush = r.flush;
        wb_we = r.wb_we;
        wb_rd = r.wb_rd;
        wb_data = r.wb_data;
        @(negedge clk);
        check_ex_out(exp_mem, ex_out);
        check_bit("branch_taken", exp_taken, branch_taken);
        if (exp_taken) begin
            check_word("branch_target", exp_target, branch_target);
        end
        check_bit("id_stall", exp_stall, id_stall);

        nxt = predict(r.pc, r.inst, ds_flag, nt, ntg);
        cti = r.inst[6:0] == isa_pkg::OPC_BRANCH || r.inst[6:0] == isa_pkg::OPC_JAL ||
              r.inst[6:0] == isa_pkg::OPC_JALR;
        if (r.flush) begin
            exp_mem = '0;
            exp_ex = '0;
            exp_taken = 1'b0;
            ds_flag = 1'b0;
        end else begin
            exp_mem = exp_ex;
            if (exp_stall) begin
                exp_ex = '0;
                exp_taken = 1'b0;
            end else begin
                exp_ex = nxt;
                exp_taken = nt;
                exp_target = ntg;
                ds_flag = cti;
            end
        end
        if (r.wb_we && r.wb_rd != 5'd0) begin
            rf[r.wb_rd] = r.wb_data;
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $finish;
    endtask

    initial begin
        row_t pre;
        clk = 1'b0;
        rst = 1'b1;
        if_pc = '0;
        if_inst = '0;
        flush = 1'b0;
        wb_we = 1'b0;
        wb_rd = '0;
        wb_data = '0;
        errors = 0;
        checks = 0;
        rng = 32'd69476;
        next_pc = 32'h0000_0100;
        exp_ex = '0;
        exp_mem = '0;
        exp_taken = 1'b0;
        exp_target = '0;
        ds_flag = 1'b0;
        for (int i = 0; i < 32; i++) begin
            rf[i] = '0;
        end

        add_row(enc_r(7'h00, 2, 1, 3'b000, 5), 0, 0, 1, 10, 32'hFFFF_FFF0);
        add_row(enc_r(7'h20, 4, 3, 3'b000, 6), 0, 0, 1, 11, 32'd5);
        add_row(enc_r(7'h00, 2, 1, 3'b001, 7), 0, 0, 1, 0, 32'hDEAD_BEEF);
        add_row(enc_r(7'h00, 11, 10, 3'b010, 8));
        add_row(enc_r(7'h00, 11, 10, 3'b011, 9));
        add_row(enc_r(7'h00, 3, 1, 3'b100, 12));
        add_row(enc_r(7'h00, 2, 10, 3'b101, 13));
        add_row(enc_r(7'h20, 2, 10, 3'b101, 14));
        add_row(enc_r(7'h00, 4, 1, 3'b110, 15));
        add_row(enc_r(7'h00, 4, 1, 3'b111, 16));
        add_row(enc_r(7'h00, 0, 0, 3'b000, 17));
        add_row(enc_i(-7, 1, 3'b000, 18, isa_pkg::OPC_OP_IMM));
        add_row(enc_i(3, 10, 3'b010, 19, isa_pkg::OPC_OP_IMM));
        add_row(enc_i(-1, 11, 3'b011, 19, isa_pkg::OPC_OP_IMM));
        add_row(enc_i(12'h5A5, 1, 3'b100, 20, isa_pkg::OPC_OP_IMM));
        add_row(enc_i(12'h0F0, 1, 3'b110, 20, isa_pkg::OPC_OP_IMM));
        add_row(enc_i(12'h0F0, 1, 3'b111, 20, isa_pkg::OPC_OP_IMM));
        add_row(enc_i(4, 1, 3'b001, 21, isa_pkg::OPC_OP_IMM));
        add_row(enc_i(8, 10, 3'b101, 22, isa_pkg::OPC_OP_IMM));
        add_row(enc_i(12'h408, 10, 3'b101, 23, isa_pkg::OPC_OP_IMM));
        add_row(enc_u(20'hABCDE, 24, isa_pkg::OPC_LUI));
        add_row(enc_u(20'h12345, 25, isa_pkg::OPC_AUIPC));
        add_row(enc_i(16, 1, 3'b010, 26, isa_pkg::OPC_LOAD));
        add_row(enc_i(-4, 2, 3'b000, 27, isa_pkg::OPC_LOAD));
        add_row(enc_s(8, 3, 1, 3'b010));
        add_row(enc_s(-2, 4, 2, 3'b001));
        // Branches, some with a plain delay slot and some back to back
        add_row(enc_b(16, 3, 3, 3'b000));
        add_row(enc_r(7'h00, 2, 1, 3'b000, 5));
        add_row(enc_b(-8, 11, 10, 3'b000));
        add_row(enc_i(1, 1, 3'b000, 5, isa_pkg::OPC_OP_IMM));
        add_row(enc_b(32, 11, 10, 3'b001));
        add_row(enc_b(32, 3, 3, 3'b001));
        add_row(enc_b(-16, 11, 10, 3'b100));
        add_row(enc_b(-16, 10, 11, 3'b100));
        add_row(enc_b(64, 10, 11, 3'b101));
        add_row(enc_b(64, 11, 10, 3'b101));
        add_row(enc_b(128, 10, 11, 3'b110));
        add_row(enc_b(128, 11, 10, 3'b110));
        add_row(enc_b(-128, 11, 10, 3'b111));
        add_row(enc_b(-128, 10, 11, 3'b111));
        add_row(enc_r(7'h00, 2, 1, 3'b000, 5));
        add_row(enc_j(64, 1));
        add_row(enc_r(7'h00, 4, 3, 3'b000, 6));
        add_row(enc_i(13, 3, 3'b000, 2, isa_pkg::OPC_JALR));
        add_row(enc_r(7'h00, 4, 3, 3'b000, 6));
        // Load-use on rs1, on rs2, then an independent follower
        add_row(enc_i(0, 1, 3'b010, 7, isa_pkg::OPC_LOAD));
        add_row(enc_r(7'h00, 9, 7, 3'b000, 8), 1);
        add_row(enc_i(4, 1, 3'b010, 7, isa_pkg::OPC_LOAD));
        add_row(enc_s(4, 7, 2, 3'b010), 1);
        add_row(enc_i(8, 1, 3'b010, 7, isa_pkg::OPC_LOAD));
        add_row(enc_r(7'h00, 9, 1, 3'b000, 8));
        add_row(enc_r(7'h00, 7, 2, 3'b110, 9));
        // Flush drops both instructions in flight
        add_row(enc_r(7'h00, 2, 1, 3'b000, 5));
        add_row(enc_r(7'h20, 2, 1, 3'b000, 6), 0, 1);
        add_row(enc_r(7'h00, 2, 1, 3'b100, 12));
        add_row(enc_i(5, 1, 3'b000, 13, isa_pkg::OPC_OP_IMM));
        add_row(32'h0000_0000);
        add_row(32'h0000_0000);

        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        // Register preload through the write port, with an idle pipeline
        for (int i = 1; i < 32; i++) begin
            rng = xorshift32(rng);
            pre = '0;
            pre.wb_we = 1'b1;
            pre.wb_rd = i[4:0];
            pre.wb_data = rng;
            run_cycle(pre, 1'b0);
        end

        foreach (rows[i]) begin
            waited = 0;
            run_cycle(rows[i], rows[i].bubble);
            while (id_stall === 1'b1) begin
                waited++;
                if (waited >= 50) begin
                    abort_run("Timeout: id_stall stayed high for 50 cycles");
                end
                run_cycle(rows[i], 1'b0);
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
